// File: include/tia_ball_params.svh
`ifndef TIA_BALL_PARAMS_SVH
`define TIA_BALL_PARAMS_SVH

// Register write addresses of the ball and the registers it shares.
`define ADDR_ENABL   6'h1F
`define ADDR_VDELBL  6'h27
`define ADDR_CTRLPF  6'h0A
`define ADDR_RESBL   6'h14
`define ADDR_HMBL    6'h24
`define ADDR_HMOVE   6'h2A
`define ADDR_HMCLR   6'h2B
`define ADDR_GRP1    6'h1C

`define LFSR_W       6
`define LINE_PIXELS  160        // Counting clocks in one full pass of the counter.
`define LFSR_END     6'b101101  // Fortieth state, the counter reloads after it.

// Index of the first drawn pixel, one LFSR state after the zero load.
`define DRAW_OFFSET  4

`endif

// File: rtl/tia_ball_pkg.sv
`default_nettype none

`include "tia_ball_params.svh"

package tia_ball_pkg;

    typedef logic [`LFSR_W-1:0] lfsr_t;
    typedef logic [5:0]         reg_addr_t;
    typedef logic [7:0]         reg_data_t;
    typedef logic signed [3:0]  hmove_t;      // Two's complement motion value.
    typedef logic [1:0]         ball_size_t;  // Width 1, 2, 4 or 8 pixels.

    // The four phases of the divided counting clock.
    typedef enum logic [1:0] {
        phi_a,
        phi_b,
        phi_c,
        phi_d
    } phase_t;

endpackage

`default_nettype wire

// File: rtl/tia_ball_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "tia_ball_params.svh"

module tia_ball_regs (
    input  wire                      clkp,
    input  wire                      rst,
    input  wire                      we,
    input  wire tia_ball_pkg::reg_addr_t addr,
    input  wire tia_ball_pkg::reg_data_t data,
    output logic                     enabl_new,
    output logic                     vdelbl,
    output logic                     grp1_stb,
    output logic                     resbl_stb,
    output logic                     hmove_stb,
    output tia_ball_pkg::ball_size_t ball_size,
    output tia_ball_pkg::hmove_t     hmbl
);

    always_ff @(posedge clkp) begin
        if (rst) begin
            enabl_new <= 1'b0;
            vdelbl    <= 1'b0;
            ball_size <= '0;
            hmbl      <= '0;
            resbl_stb <= 1'b0;
            hmove_stb <= 1'b0;
            grp1_stb  <= 1'b0;
        end else begin
            resbl_stb <= 1'b0;  // Strobes last one cycle unless written again.
            hmove_stb <= 1'b0;
            grp1_stb  <= 1'b0;
            if (we) begin
                case (addr)
                    `ADDR_ENABL:  enabl_new <= data[1];
                    `ADDR_VDELBL: vdelbl    <= data[0];
                    `ADDR_CTRLPF: ball_size <= data[5:4];
                    `ADDR_HMBL:   hmbl      <= data[7:4];
                    `ADDR_HMCLR:  hmbl      <= '0;
                    `ADDR_RESBL:  resbl_stb <= 1'b1;
                    `ADDR_HMOVE:  hmove_stb <= 1'b1;
                    `ADDR_GRP1:   grp1_stb  <= 1'b1;  // Data is ignored here.
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/tia_biphase_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tia_biphase_clock (
    input  wire                  clkp,
    input  wire                  rst,
    input  wire                  restart,
    input  wire                  cnt_en,
    output tia_ball_pkg::phase_t phase,
    output logic                 step
);

    import tia_ball_pkg::*;

    phase_t phase_next;

    always_comb begin
        case (phase)
            phi_a:   phase_next = phi_b;
            phi_b:   phase_next = phi_c;
            phi_c:   phase_next = phi_d;
            default: phase_next = phi_a;
        endcase
    end

    always_ff @(posedge clkp) begin
        if (rst || restart) begin
            phase <= phi_a;
        end else if (cnt_en) begin
            phase <= phase_next;
        end
    end

    // One step per four counting clocks, on the wrap from phi_d back to phi_a.
    // A restart wins over the step.
    assign step = cnt_en & ~restart & (phase == phi_d);

endmodule

`default_nettype wire

// File: rtl/tia_ball_position_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "tia_ball_params.svh"

module tia_ball_position_counter (
    input  wire                  clkp,
    input  wire                  rst,
    input  wire                  hblank,
    input  wire                  extra_clk,
    input  wire                  resbl_stb,
    output logic                 start,
    output tia_ball_pkg::phase_t phase,
    output logic                 cnt_en
);

    import tia_ball_pkg::*;

    lfsr_t lfsr;
    logic  step;
    logic  lfsr_end;
    logic  lfsr_err;
    logic  lfsr_fb;

    // The counter runs through the visible line, and during blanking only
    // on the extra clocks from the motion block.
    assign cnt_en = ~hblank | extra_clk;

    tia_biphase_clock biphase_i (
        .clkp    (clkp),
        .rst     (rst),
        .restart (resbl_stb),
        .cnt_en  (cnt_en),
        .phase   (phase),
        .step    (step)
    );

    assign lfsr_end = (lfsr == `LFSR_END);
    assign lfsr_err = &lfsr;  // Never reached from zero.
    assign lfsr_fb  = ~(lfsr[`LFSR_W-1] ^ lfsr[`LFSR_W-2]);

    // Forty states from zero to the end code, four counting clocks each.
    always_ff @(posedge clkp) begin
        if (rst || resbl_stb) begin
            lfsr <= '0;
        end else if (step) begin
            if (lfsr_end || lfsr_err) begin
                lfsr <= '0;
            end else begin
                lfsr <= {lfsr[`LFSR_W-2:0], lfsr_fb};
            end
        end
    end

    // Set for the state that follows the zero load, which covers pixels
    // DRAW_OFFSET to DRAW_OFFSET plus 3.
    always_ff @(posedge clkp) begin
        if (rst || resbl_stb) begin
            start <= 1'b0;
        end else if (step) begin
            start <= (lfsr == '0);
        end
    end

endmodule

`default_nettype wire

// File: rtl/tia_ball_motion.sv
`timescale 1ns/100ps
`default_nettype none

module tia_ball_motion (
    input  wire                  clkp,
    input  wire                  rst,
    input  wire                  hblank,
    input  wire                  hmove_stb,
    input  wire tia_ball_pkg::hmove_t hmbl,
    output logic                 extra_clk
);

    logic [3:0] pending;  // Extra counting clocks still owed.
    logic [1:0] gap_cnt;  // Cycles left before the next pulse may go out.

    // A pulse waits while the line is visible.
    assign extra_clk = hblank & (pending != 4'd0) & (gap_cnt == 2'd0);

    always_ff @(posedge clkp) begin
        if (rst) begin
            pending <= 4'd0;
            gap_cnt <= 2'd0;
        end else if (hmove_stb) begin
            // Flipping the sign bit adds 8, so -8 to 7 maps onto 0 to 15.
            pending <= hmbl ^ 4'b1000;
            gap_cnt <= 2'd0;
        end else if (extra_clk) begin
            pending <= pending - 4'd1;
            gap_cnt <= 2'd3;
        end else if (gap_cnt != 2'd0) begin
            gap_cnt <= gap_cnt - 2'd1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tia_ball_graphics.sv
`timescale 1ns/100ps
`default_nettype none

module tia_ball_graphics (
    input  wire                      clkp,
    input  wire                      rst,
    input  wire                      cnt_en,
    input  wire                      start,
    input  wire tia_ball_pkg::phase_t    phase,
    input  wire                      enabl_new,
    input  wire                      vdelbl,
    input  wire                      grp1_stb,
    input  wire tia_ball_pkg::ball_size_t ball_size,
    output logic                     bl
);

    import tia_ball_pkg::*;

    logic enabl_old;
    logic start_d;
    logic eff_en;
    logic in_win;

    // Vertical delay copy, taken when player 1 graphics are written.
    always_ff @(posedge clkp) begin
        if (rst) begin
            enabl_old <= 1'b0;
        end else if (grp1_stb) begin
            enabl_old <= enabl_new;
        end
    end

    // High for the LFSR state after start, the second half of the wide ball.
    always_ff @(posedge clkp) begin
        if (rst) begin
            start_d <= 1'b0;
        end else if (cnt_en && phase == phi_d) begin
            start_d <= start;
        end
    end

    assign eff_en = vdelbl ? enabl_old : enabl_new;

    always_comb begin
        case (ball_size)
            2'd0:    in_win = start & (phase == phi_a);
            2'd1:    in_win = start & (phase == phi_a || phase == phi_b);
            2'd2:    in_win = start;
            default: in_win = start | start_d;
        endcase
    end

    always_ff @(posedge clkp) begin
        if (rst) begin
            bl <= 1'b0;
        end else begin
            bl <= cnt_en & in_win & eff_en;  // No pixel without a counting clock.
        end
    end

endmodule

`default_nettype wire

// File: rtl/tia_ball.sv
`timescale 1ns/100ps
`default_nettype none

module tia_ball (
    input  wire                      clkp,
    input  wire                      rst,
    input  wire                      we,
    input  wire tia_ball_pkg::reg_addr_t addr,
    input  wire tia_ball_pkg::reg_data_t data,
    input  wire                      hblank,
    output logic                     bl
);

    import tia_ball_pkg::*;

    logic       enabl_new;
    logic       vdelbl;
    logic       grp1_stb;
    logic       resbl_stb;
    logic       hmove_stb;
    ball_size_t ball_size;
    hmove_t     hmbl;
    logic       extra_clk;
    logic       start;
    phase_t     phase;
    logic       cnt_en;

    tia_ball_regs regs_i (
        .clkp      (clkp),
        .rst       (rst),
        .we        (we),
        .addr      (addr),
        .data      (data),
        .enabl_new (enabl_new),
        .vdelbl    (vdelbl),
        .grp1_stb  (grp1_stb),
        .resbl_stb (resbl_stb),
        .hmove_stb (hmove_stb),
        .ball_size (ball_size),
        .hmbl      (hmbl)
    );

    tia_ball_position_counter position_i (
        .clkp      (clkp),
        .rst       (rst),
        .hblank    (hblank),
        .extra_clk (extra_clk),
        .resbl_stb (resbl_stb),
        .start     (start),
        .phase     (phase),
        .cnt_en    (cnt_en)
    );

    tia_ball_motion motion_i (
        .clkp      (clkp),
        .rst       (rst),
        .hblank    (hblank),
        .hmove_stb (hmove_stb),
        .hmbl      (hmbl),
        .extra_clk (extra_clk)
    );

    tia_ball_graphics graphics_i (
        .clkp      (clkp),
        .rst       (rst),
        .cnt_en    (cnt_en),
        .start     (start),
        .phase     (phase),
        .enabl_new (enabl_new),
        .vdelbl    (vdelbl),
        .grp1_stb  (grp1_stb),
        .ball_size (ball_size),
        .bl        (bl)
    );

endmodule

`default_nettype wire

// File: sim/tia_ball_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module tia_ball_assertions (
    input wire clkp,
    input wire rst,
    input wire hblank,
    input wire cnt_en,
    input wire extra_clk,
    input wire bl
);

    int fail_count = 0;

    // A pixel is only drawn on a counting clock.
    assert property (@(posedge clkp) disable iff (rst) !cnt_en |=> !bl)
        else begin
            $error("bl is high after a cycle without a counting clock");
            fail_count++;
        end

    assert property (@(posedge clkp) disable iff (rst) extra_clk |-> hblank)
        else begin
            $error("extra_clk is high outside horizontal blanking");
            fail_count++;
        end

    // Extra clocks never come back to back.
    assert property (@(posedge clkp) disable iff (rst) extra_clk |=> !extra_clk)
        else begin
            $error("extra_clk is high in two consecutive cycles");
            fail_count++;
        end

endmodule

bind tia_ball tia_ball_assertions assertions_i (
    .clkp      (clkp),
    .rst       (rst),
    .hblank    (hblank),
    .cnt_en    (cnt_en),
    .extra_clk (extra_clk),
    .bl        (bl)
);

`default_nettype wire

// File: sim/tia_ball_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "tia_ball_params.svh"

module tia_ball_checker (
    input  wire                      clkp,
    input  wire                      rst,
    input  wire                      we,
    input  wire tia_ball_pkg::reg_addr_t addr,
    input  wire tia_ball_pkg::reg_data_t data,
    input  wire                      hblank,
    input  wire                      bl,
    output int                       error_count,
    output int                       check_count
);

    import tia_ball_pkg::*;

    logic       enabl_new;
    logic       enabl_old;
    logic       vdelbl;
    ball_size_t ball_size;
    hmove_t     hmbl;
    logic       resbl_seen;  // Strobes of the model, acted on one cycle after the write.
    logic       hmove_seen;
    logic       grp1_seen;
    int         pix;
    int         pending;
    int         gap;
    logic       exp_bl;
    logic       exp_valid = 1'b0;

    // Expected pixel from the output rule.
    function automatic logic ball_pixel(input logic counting, input int p,
                                        input ball_size_t size, input logic en);
        int width;
        width = 1 << size;
        return counting && en && (p >= `DRAW_OFFSET) && (p < `DRAW_OFFSET + width);
    endfunction

    initial begin
        error_count = 0;
        check_count = 0;
    end

    always @(posedge clkp) begin : model
        logic extra;
        logic counting;
        logic eff_en;
        if (rst) begin
            enabl_new  = 1'b0;
            enabl_old  = 1'b0;
            vdelbl     = 1'b0;
            ball_size  = '0;
            hmbl       = '0;
            resbl_seen = 1'b0;
            hmove_seen = 1'b0;
            grp1_seen  = 1'b0;
            pix        = 0;
            pending    = 0;
            gap        = 0;
            exp_bl     = 1'b0;
        end else begin
            extra    = hblank && (pending != 0) && (gap == 0);
            counting = !hblank || extra;
            eff_en   = vdelbl ? enabl_old : enabl_new;
            exp_bl   = ball_pixel(counting, pix, ball_size, eff_en);
            if (resbl_seen) begin
                pix = 0;
            end else if (counting) begin
                pix = (pix + 1) % `LINE_PIXELS;
            end
            if (grp1_seen) enabl_old = enabl_new;
            if (hmove_seen) begin
                pending = int'(hmbl) + 8;  // Motion range -8 to 7 gives 0 to 15 clocks.
                gap     = 0;
            end else if (extra) begin
                pending = pending - 1;
                gap     = 3;
            end else if (gap != 0) begin
                gap = gap - 1;
            end
            resbl_seen = 1'b0;
            hmove_seen = 1'b0;
            grp1_seen  = 1'b0;
            if (we) begin
                case (addr)
                    `ADDR_ENABL:  enabl_new = data[1];
                    `ADDR_VDELBL: vdelbl = data[0];
                    `ADDR_CTRLPF: ball_size = data[5:4];
                    `ADDR_HMBL:   hmbl = data[7:4];
                    `ADDR_HMCLR:  hmbl = '0;
                    `ADDR_RESBL:  resbl_seen = 1'b1;
                    `ADDR_HMOVE:  hmove_seen = 1'b1;
                    `ADDR_GRP1:   grp1_seen = 1'b1;
                    default: ;
                endcase
            end
        end
        exp_valid = 1'b1;
    end

    // Outputs are stable half a cycle after the edge.
    always @(negedge clkp) begin
        if (exp_valid) begin
            check_count++;
            if (bl !== exp_bl) begin
                error_count++;
                $display("mismatch bl expected %h got %h at %0t", exp_bl, bl, $time);
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tia_ball_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tia_ball_params.svh"

module tia_ball_tb;

    import tia_ball_pkg::*;

    localparam int LINE_CYCLES    = 228;
    localparam int HBLANK_CYCLES  = 68;
    localparam int TIMEOUT_CYCLES = 12 * LINE_CYCLES + 200;

    logic      clkp;
    logic      rst;
    logic      we;
    reg_addr_t addr;
    reg_data_t data;
    logic      hblank;
    logic      bl;
    int        error_count;
    int        check_count;
    int        hpos = 0;
    int        cycle_cnt;

    tia_ball tia_ball_i (
        .clkp   (clkp),
        .rst    (rst),
        .we     (we),
        .addr   (addr),
        .data   (data),
        .hblank (hblank),
        .bl     (bl)
    );

    tia_ball_checker checker_i (
        .clkp        (clkp),
        .rst         (rst),
        .we          (we),
        .addr        (addr),
        .data        (data),
        .hblank      (hblank),
        .bl          (bl),
        .error_count (error_count),
        .check_count (check_count)
    );

    initial begin
        clkp = 1'b0;
        forever #20 clkp = ~clkp;
    end

    // Line timing, blanking over the first 68 cycles of each line.
    always @(posedge clkp) begin
        if (rst || hpos == LINE_CYCLES - 1) begin
            hpos   <= 0;
            hblank <= 1'b1;
        end else begin
            hpos   <= hpos + 1;
            hblank <= (hpos + 1 < HBLANK_CYCLES);
        end
    end

    task automatic write_reg(input reg_addr_t a, input reg_data_t d);
        @(posedge clkp);
        we   <= 1'b1;
        addr <= a;
        data <= d;
        @(posedge clkp);
        we   <= 1'b0;
    endtask

    // Returns on the edge that opens the next line.
    task automatic wait_line_start();
        @(posedge clkp);
        while (hpos != LINE_CYCLES - 1) @(posedge clkp);
    endtask

    initial begin : stimulus
        logic [3:0] motion;
        reg_data_t  rnd;
        void'($urandom(32'hc213));
        rst    = 1'b1;
        we     = 1'b0;
        addr   = '0;
        data   = '0;
        hblank = 1'b1;
        repeat (2) @(posedge clkp);
        rst <= 1'b0;
        wait_line_start();  // First line runs with all registers cleared.
        write_reg(`ADDR_RESBL, 8'h00);
        write_reg(`ADDR_ENABL, 8'h02);
        for (int s = 0; s < 4; s++) begin
            write_reg(`ADDR_CTRLPF, reg_data_t'(s << 4));
            wait_line_start();
        end
        // With VDELBL set the old copy keeps the ball on after ENABL clears.
        write_reg(`ADDR_CTRLPF, 8'h20);
        write_reg(`ADDR_VDELBL, 8'h01);
        write_reg(`ADDR_GRP1, 8'h00);
        write_reg(`ADDR_ENABL, 8'h00);
        wait_line_start();
        write_reg(`ADDR_GRP1, 8'h00);
        wait_line_start();
        write_reg(`ADDR_VDELBL, 8'h00);
        write_reg(`ADDR_ENABL, 8'h02);
        wait_line_start();
        for (int n = 0; n < 2; n++) begin
            motion = $urandom % 16;
            rnd    = $urandom % 256;
            write_reg(`ADDR_HMBL, {motion, 4'h0});
            write_reg(`ADDR_HMOVE, 8'h00);
            write_reg(`ADDR_ENABL, (n == 0) ? rnd : 8'h02);
            wait_line_start();
        end
        write_reg(`ADDR_HMCLR, 8'h00);
        write_reg(`ADDR_HMOVE, 8'h00);
        wait_line_start();
        repeat (2) @(posedge clkp);
        $display("checks %0d errors %0d assertion failures %0d", check_count, error_count,
                 tia_ball_i.assertions_i.fail_count);
        if (error_count == 0 && tia_ball_i.assertions_i.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clkp);
            cycle_cnt++;
        end
        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks %0d errors %0d assertion failures %0d", check_count, error_count,
                 tia_ball_i.assertions_i.fail_count);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
rtl/tia_ball_pkg.sv
rtl/tia_ball_regs.sv
rtl/tia_biphase_clock.sv
rtl/tia_ball_position_counter.sv
rtl/tia_ball_motion.sv
rtl/tia_ball_graphics.sv
rtl/tia_ball.sv
sim/tia_ball_assertions.sv
sim/tia_ball_checker.sv
sim/tia_ball_tb.sv

// File: Bender.yml
package:
  name: tia_ball

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/tia_ball_pkg.sv
      - rtl/tia_ball_regs.sv
      - rtl/tia_biphase_clock.sv
      - rtl/tia_ball_position_counter.sv
      - rtl/tia_ball_motion.sv
      - rtl/tia_ball_graphics.sv
      - rtl/tia_ball.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tia_ball_assertions.sv
      - sim/tia_ball_checker.sv
      - sim/tia_ball_tb.sv
